// ==== vga_stream_pkg.sv ====
// vga stream shared definitions
package vga_stream_pkg;

  // opcode field of an instruction word
  // value 3 behaves like a frame fill
  typedef enum logic [1:0] {
    OP_RUN        = 2'd0,  // count plus one active pixels
    OP_LINE_FILL  = 2'd1,  // to the end of the current line
    OP_FRAME_FILL = 2'd2   // to the end of the frame, fetch stops
  } opcode_e;

  // rgb333, red in the top three bits
  typedef logic [8:0] colour_t;

  // 20-bit display list word
  typedef struct packed {
    opcode_e    opcode;  // bits 19:18
    colour_t    colour;  // bits 17:9
    logic [8:0] count;   // bits 8:0
  } instr_t;

  // quad i/o fast read
  localparam logic [7:0] CMD_QUAD_READ = 8'hEB;

  // one instruction word is five nibbles on the quad bus
  localparam int NIBBLES_PER_WORD = 5;

  // continuous-read mode bits sent after the address
  localparam int MODE_NIBBLES = 2;

endpackage

// ==== word_stream_if.sv ====
// instruction word stream
`timescale 1ns/1ps

interface word_stream_if;

  vga_stream_pkg::instr_t word;
  logic                   valid;    // level, a word is offered
  logic                   take;     // strobe, word consumed this cycle
  logic                   restart;  // pulse, flush and refetch from address 0

  modport producer (
    output word,
    output valid,
    input  take,
    input  restart
  );

  modport consumer (
    input  word,
    input  valid,
    output take,
    output restart
  );

endinterface

// ==== qspi_reader.sv ====
// quad spi display list reader
`timescale 1ns/1ps

module qspi_reader (
  input  logic       clk,
  input  logic       rst,
  input  logic [1:0] spi_latency,
  input  logic [3:0] io_in,
  output logic       spi_clk,
  output logic       cs_n,
  output logic [3:0] io_out,
  output logic [3:0] io_oe,
  word_stream_if.producer fetch
);

  localparam logic [7:0] CMD = vga_stream_pkg::CMD_QUAD_READ;
  localparam logic [2:0] MODE_LAST = 3'(vga_stream_pkg::MODE_NIBBLES - 1);
  localparam logic [2:0] WORD_LAST = 3'(vga_stream_pkg::NIBBLES_PER_WORD - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_GAP,    // cs_n high for one spi cycle
    ST_CMD,
    ST_ADDR,
    ST_MODE,
    ST_DUMMY,
    ST_DATA
  } state_e;

  state_e      state;
  logic [2:0]  cnt;    // bit or nibble index within the phase
  logic [15:0] shift;  // leading nibbles of the word in progress
  logic        last_nib;
  logic        stall;
  logic        sample;

  assign last_nib = (cnt == WORD_LAST);

  // last nibble waits on the bus while the held word is unconsumed
  assign stall = (state == ST_DATA) && !spi_clk && last_nib &&
                 fetch.valid && !fetch.take;

  // capture on the rising spi_clk edge
  assign sample = (state == ST_DATA) && !spi_clk && !stall && !fetch.restart;

  assign cs_n = (state == ST_IDLE) || (state == ST_GAP);

  always_comb begin
    io_out = 4'h0;
    io_oe  = 4'h0;
    case (state)
      ST_CMD: begin
        io_out = {2'b11, 1'b0, CMD[3'd7 - cnt]};  // wp and hold kept high
        io_oe  = 4'b1101;
      end
      ST_ADDR: io_oe = 4'hf;  // start address is zero
      ST_MODE: begin
        io_out = 4'hf;  // mode ff, no continuous read
        io_oe  = 4'hf;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ST_IDLE;
      cnt         <= '0;
      spi_clk     <= 1'b0;
      fetch.valid <= 1'b0;
    end else if (fetch.restart) begin
      state       <= ST_GAP;  // drop the held word and reopen the read
      cnt         <= '0;
      spi_clk     <= 1'b0;
      fetch.valid <= 1'b0;
    end else begin
      if (fetch.take)
        fetch.valid <= 1'b0;
      case (state)
        ST_IDLE: ;
        ST_GAP: begin
          cnt <= cnt + 3'd1;
          if (cnt == 3'd1) begin
            state <= ST_CMD;
            cnt   <= '0;
          end
        end
        default: begin
          if (!spi_clk) begin
            spi_clk <= !stall;
            if (sample && last_nib)
              fetch.valid <= 1'b1;  // word complete
          end else begin
            spi_clk <= 1'b0;  // falling edge ends one spi cycle
            cnt     <= cnt + 3'd1;
            case (state)
              ST_CMD: if (cnt == 3'd7) begin
                state <= ST_ADDR;
                cnt   <= '0;
              end
              ST_ADDR: if (cnt == 3'd5) begin
                state <= ST_MODE;
                cnt   <= '0;
              end
              ST_MODE: if (cnt == MODE_LAST) begin
                state <= ST_DUMMY;
                cnt   <= '0;
              end
              ST_DUMMY: if (cnt == {1'b0, spi_latency}) begin
                state <= ST_DATA;
                cnt   <= '0;
              end
              default: if (last_nib) cnt <= '0;
            endcase
          end
        end
      endcase
    end
  end

  // first nibble lands in the top bits
  always_ff @(posedge clk) begin
    if (sample) begin
      if (last_nib)
        fetch.word <= vga_stream_pkg::instr_t'({shift, io_in});
      else
        shift <= {shift[11:0], io_in};
    end
  end

endmodule

// ==== prefetch_buffer.sv ====
// instruction prefetch fifo
`timescale 1ns/1ps

module prefetch_buffer #(
  parameter int DEPTH = 4
) (
  input logic clk,
  input logic rst,
  word_stream_if.consumer up,
  word_stream_if.producer down
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  vga_stream_pkg::instr_t mem [DEPTH];
  logic [PW-1:0] rd_ptr;
  logic [PW-1:0] wr_ptr;
  logic [PW:0]   count;
  logic          full;
  logic          push;
  logic          pop;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full = (count == (PW + 1)'(DEPTH));

  // restart goes straight up to the reader
  assign up.restart = down.restart;
  assign up.take    = up.valid && !full && !down.restart;

  assign push = up.valid && up.take;
  assign pop  = down.valid && down.take;

  assign down.valid = (count != '0);
  assign down.word  = mem[rd_ptr];  // oldest entry

  always_ff @(posedge clk) begin
    if (rst || down.restart) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= up.word;
  end

endmodule

// ==== instr_decoder.sv ====
// run-length instruction decoder
`timescale 1ns/1ps

module instr_decoder (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    frame_start,
  input  logic                    line_start,
  input  logic                    active,
  output vga_stream_pkg::colour_t colour,
  word_stream_if.consumer instr
);

  vga_stream_pkg::instr_t cur;  // instruction being painted
  vga_stream_pkg::instr_t eff;  // instruction used for this pixel
  logic cur_valid;
  logic boot;       // one refetch right after reset
  logic need;       // nothing current, use the bus word directly
  logic run_end;    // last pixel of the current run
  logic eff_ok;
  logic eff_last;   // bus word is a run that ends on this pixel
  logic fill_open;  // current word has painted a pixel since it was loaded

  // a line fill ends where the next line starts, once it has painted
  assign need = !cur_valid ||
                (cur.opcode == vga_stream_pkg::OP_LINE_FILL && line_start && fill_open);

  assign run_end = !need && active && cur.opcode == vga_stream_pkg::OP_RUN &&
                   cur.count == '0;

  // frame fills never ask for a word, so fetch stops until restart
  assign instr.restart = frame_start || boot;
  assign instr.take    = instr.valid && !instr.restart && (need || run_end);

  assign eff    = need ? instr.word : cur;
  assign eff_ok = need ? instr.take : cur_valid;  // low means underrun

  assign eff_last = active && instr.word.opcode == vga_stream_pkg::OP_RUN &&
                    instr.word.count == '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      boot      <= 1'b1;
      cur_valid <= 1'b0;
      fill_open <= 1'b0;
      colour    <= '0;
    end else begin
      boot   <= 1'b0;
      colour <= (active && eff_ok) ? eff.colour : '0;
      if (instr.restart)
        cur_valid <= 1'b0;
      else if (run_end)
        cur_valid <= instr.take;  // preload the next word
      else if (need)
        cur_valid <= instr.take && !eff_last;
      if (need || run_end)
        fill_open <= need && active;  // a bus word paints this pixel
      else if (active)
        fill_open <= 1'b1;
    end
  end

  // a word taken while its first pixel is painted is stored one count down
  // a line fill loaded past the last pixel of a line covers the next line
  always_ff @(posedge clk) begin
    if (need || run_end) begin
      cur <= instr.word;
      if (need && active && instr.word.opcode == vga_stream_pkg::OP_RUN)
        cur.count <= instr.word.count - 9'd1;
    end else if (active && cur.opcode == vga_stream_pkg::OP_RUN) begin
      cur.count <= cur.count - 9'd1;
    end
  end

endmodule

// ==== vga_timing.sv ====
// vga sync and blank timing
`timescale 1ns/1ps

module vga_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic clk,
  input  logic rst,
  output logic hsync,
  output logic vsync,
  output logic blank,
  output logic active,
  output logic line_start,
  output logic frame_start
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int HW = $clog2(H_TOTAL);
  localparam int VW = $clog2(V_TOTAL);

  logic [HW-1:0] h_cnt;
  logic [VW-1:0] v_cnt;
  logic          h_sync_zone;
  logic          v_sync_zone;

  assign h_sync_zone = (h_cnt >= HW'(H_ACTIVE + H_FRONT)) &&
                       (h_cnt <  HW'(H_ACTIVE + H_FRONT + H_SYNC));
  assign v_sync_zone = (v_cnt >= VW'(V_ACTIVE + V_FRONT)) &&
                       (v_cnt <  VW'(V_ACTIVE + V_FRONT + V_SYNC));

  // decoder strobes, same cycle as the counters
  assign active      = (h_cnt < HW'(H_ACTIVE)) && (v_cnt < VW'(V_ACTIVE));
  assign line_start  = (h_cnt == '0) && (v_cnt < VW'(V_ACTIVE));
  assign frame_start = (h_cnt == '0) && (v_cnt == VW'(V_ACTIVE));

  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == HW'(H_TOTAL - 1)) begin
      h_cnt <= '0;
      if (v_cnt == VW'(V_TOTAL - 1))
        v_cnt <= '0;
      else
        v_cnt <= v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // one stage to line up with the decoder colour
  always_ff @(posedge clk) begin
    if (rst) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      blank <= 1'b1;
    end else begin
      hsync <= !h_sync_zone;  // active low
      vsync <= !v_sync_zone;
      blank <= !active;
    end
  end

endmodule

// ==== vga_stream_top.sv ====
// run-length vga engine top
`timescale 1ns/1ps

module vga_stream_top #(
  parameter int DEPTH    = 4,
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [1:0]              spi_latency,
  input  logic [3:0]              spi_io_in,
  output logic                    spi_clk,
  output logic                    spi_cs_n,
  output logic [3:0]              spi_io_out,
  output logic [3:0]              spi_io_oe,
  output logic                    hsync,
  output logic                    vsync,
  output logic                    blank,
  output vga_stream_pkg::colour_t colour
);

  word_stream_if fetch_bus ();  // reader to buffer
  word_stream_if instr_bus ();  // buffer to decoder

  vga_stream_pkg::colour_t dec_colour;
  logic t_hsync, t_vsync, t_blank;
  logic active, line_start, frame_start;

  qspi_reader reader_inst (
    .clk(clk), .rst(rst), .spi_latency(spi_latency), .io_in(spi_io_in),
    .spi_clk(spi_clk), .cs_n(spi_cs_n), .io_out(spi_io_out), .io_oe(spi_io_oe),
    .fetch(fetch_bus.producer)
  );

  prefetch_buffer #(.DEPTH(DEPTH)) buffer_inst (
    .clk(clk), .rst(rst), .up(fetch_bus.consumer), .down(instr_bus.producer)
  );

  instr_decoder decoder_inst (
    .clk(clk), .rst(rst), .frame_start(frame_start), .line_start(line_start),
    .active(active), .colour(dec_colour), .instr(instr_bus.consumer)
  );

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) timing_inst (
    .clk(clk), .rst(rst), .hsync(t_hsync), .vsync(t_vsync), .blank(t_blank),
    .active(active), .line_start(line_start), .frame_start(frame_start)
  );

  // output stage, black outside the visible area
  always_ff @(posedge clk) begin
    if (rst) begin
      hsync  <= 1'b1;
      vsync  <= 1'b1;
      blank  <= 1'b1;
      colour <= '0;
    end else begin
      hsync  <= t_hsync;
      vsync  <= t_vsync;
      blank  <= t_blank;
      colour <= t_blank ? '0 : dec_colour;
    end
  end

endmodule

// ==== flash_model.sv ====
// behavioural quad spi flash
`timescale 1ns/1ps

module flash_model (
  input  logic       spi_clk,
  input  logic       cs_n,
  input  logic [3:0] io_line,
  input  logic [3:0] io_oe,
  input  logic [1:0] latency,
  output logic [3:0] data_out,
  output int         error_count
);

  localparam logic [7:0] CMD = vga_stream_pkg::CMD_QUAD_READ;
  localparam int NPW = vga_stream_pkg::NIBBLES_PER_WORD;
  localparam int MODE_END = 14 + vga_stream_pkg::MODE_NIBBLES;

  logic [19:0] list [64];  // display list, loaded by the testbench
  int          list_len;
  int          edges;       // rising spi_clk edges since cs_n fell
  int          first_data;  // edges before the first data nibble
  int          k;
  int          nib;
  logic [19:0] wrd;

  assign first_data = MODE_END + int'(latency) + 1;

  initial begin
    error_count = 0;
    data_out    = 4'h0;
    list_len    = 1;
  end

  always @(posedge spi_clk or posedge cs_n) begin
    if (cs_n) begin
      edges <= 0;
    end else begin
      k = edges + 1;
      edges <= k;
      if (k <= 8) begin
        if (!io_oe[0] || io_line[0] !== CMD[8-k]) begin
          $display("flash model got a wrong command bit at edge %0d", k);
          error_count++;
        end
      end else if (k <= 14) begin
        if (io_oe != 4'hf || io_line != 4'h0) begin
          $display("flash model got a nonzero or undriven address nibble");
          error_count++;
        end
      end else if (k <= MODE_END) begin
        if (io_oe != 4'hf) begin
          $display("flash model got an undriven mode nibble");
          error_count++;
        end
      end else if (io_oe != 4'h0) begin
        $display("flash model saw the reader drive the bus during a dummy or data cycle");
        error_count++;
      end
    end
  end

  // next nibble goes out on each falling edge, msb first
  always @(negedge spi_clk) begin
    if (!cs_n && edges >= first_data) begin
      nib = edges - first_data;
      wrd = list[(nib / NPW) % list_len];
      data_out <= wrd[19 - 4 * (nib % NPW) -: 4];
    end
  end

endmodule

// ==== tb_vga_stream.sv ====
// vga stream engine testbench
`timescale 1ns/1ps

module tb_vga_stream;

  localparam int H_ACT = 16;
  localparam int H_SYNC = 3;
  localparam int V_ACT = 4;
  localparam int FRAME_CYCLES = (16 + 2 + 3 + 3) * (4 + 1 + 1 + 2);
  localparam int FRAME_PIX = H_ACT * V_ACT;
  localparam int NUM_TESTS = 9;
  localparam int CYCLE_LIMIT = 10 * FRAME_CYCLES * NUM_TESTS + 2000;

  logic clk, rst, spi_clk, spi_cs_n, hsync, vsync, blank;
  logic [1:0] spi_latency;
  logic [3:0] spi_io_out, spi_io_oe, flash_io, io_line;
  vga_stream_pkg::colour_t colour;
  logic [19:0] lst [64];
  logic [8:0]  exp_pix [FRAME_PIX];
  int lst_len, passed, failed, errs, flash_errors, flash_start;
  int cycles = 0;

  assign io_line = (spi_io_oe & spi_io_out) | (~spi_io_oe & flash_io);

  vga_stream_top #(.DEPTH(4), .H_ACTIVE(16), .H_FRONT(2), .H_SYNC(3), .H_BACK(3),
    .V_ACTIVE(4), .V_FRONT(1), .V_SYNC(1), .V_BACK(2)) UUT (
    .clk(clk), .rst(rst), .spi_latency(spi_latency), .spi_io_in(io_line),
    .spi_clk(spi_clk), .spi_cs_n(spi_cs_n), .spi_io_out(spi_io_out),
    .spi_io_oe(spi_io_oe), .hsync(hsync), .vsync(vsync), .blank(blank), .colour(colour)
  );

  flash_model flash_inst (.spi_clk(spi_clk), .cs_n(spi_cs_n), .io_line(io_line),
    .io_oe(spi_io_oe), .latency(spi_latency), .data_out(flash_io),
    .error_count(flash_errors));

  initial begin
    clk = 1'b0;
    forever #50 clk = !clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, a test did not finish", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input string what, input int e, input int a);
    if (e != a) begin
      $display("Mismatch %s %s expected %0h actual %0h", name, what, e, a);
      errs++;
    end
  endtask

  // list goes into the flash while reset is held
  task automatic start_test(input logic [1:0] lat);
    int i;
    errs = 0;
    flash_start = flash_errors;
    @(posedge clk);
    rst <= 1'b1;
    spi_latency <= lat;
    for (i = 0; i < lst_len; i++)
      flash_inst.list[i] = lst[i];
    flash_inst.list_len = lst_len;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic report(input string name);
    if (flash_errors != flash_start) begin
      $display("flash protocol error during test %s", name);
      errs++;
    end
    if (errs == 0) passed++;
    else failed++;
    $display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  // run-length rules applied to the list for one frame
  task automatic build_expected;
    int p, i, rem;
    logic [19:0] w;
    p = 0;
    i = 0;
    while (p < FRAME_PIX) begin
      w = lst[i % lst_len];
      if (w[19:18] == 2'd0) rem = int'(w[8:0]) + 1;
      else if (w[19:18] == 2'd1) rem = H_ACT - p % H_ACT;  // rest of this line
      else rem = FRAME_PIX - p;
      while (rem > 0 && p < FRAME_PIX) begin
        exp_pix[p] = w[17:9];
        p++;
        rem--;
      end
      i++;
    end
  endtask

  task automatic wait_vsync;
    @(negedge clk);
    while (vsync !== 1'b0) @(negedge clk);
  endtask

  // frames after the first vsync are fetched from a clean restart
  task automatic run_list(input string name, input logic [1:0] lat, input int frames);
    int i;
    start_test(lat);
    build_expected;
    wait_vsync;
    i = 0;
    while (i < frames * FRAME_PIX) begin
      @(negedge clk);
      if (!blank) begin
        check_value(name, $sformatf("pixel %0d", i), exp_pix[i % FRAME_PIX], colour);
        i++;
      end
    end
    report(name);
  endtask

  task automatic test_reset_state;
    lst[0] = {2'd2, 9'h0f0, 9'd0};
    lst_len = 1;
    start_test(2'd0);
    @(negedge clk);
    check_value("reset_state", "cs_n", 1, spi_cs_n);
    check_value("reset_state", "spi_clk", 0, spi_clk);
    check_value("reset_state", "io_oe", 0, spi_io_oe);
    check_value("reset_state", "hsync", 1, hsync);
    check_value("reset_state", "vsync", 1, vsync);
    check_value("reset_state", "blank", 1, blank);
    check_value("reset_state", "colour", 0, colour);
    report("reset_state");
  endtask

  task automatic test_sync_shape;
    int n, pulses, width, vs_low;
    pulses = 0;
    width = 0;
    vs_low = 0;
    start_test(2'd0);
    wait_vsync;
    for (n = 0; n < FRAME_CYCLES; n++) begin
      if (!vsync) vs_low++;
      if (!hsync) width++;
      else if (width != 0) begin
        pulses++;
        check_value("sync_shape", "hsync width", H_SYNC, width);
        width = 0;
      end
      if (blank && colour != 9'h0) begin
        $display("colour is not black during blank in sync_shape");
        errs++;
      end
      @(negedge clk);
    end
    check_value("sync_shape", "hsync pulses", 8, pulses);
    check_value("sync_shape", "vsync low cycles", 24, vs_low);
    report("sync_shape");
  endtask

  task automatic load_runs;
    lst[0] = {2'd0, 9'h1a3, 9'd9};
    lst[1] = {2'd0, 9'h055, 9'd19};  // crosses the first line end
    lst[2] = {2'd0, 9'h1c0, 9'd14};
    lst[3] = {2'd2, 9'h0f0, 9'd0};
    lst_len = 4;
  endtask

  task automatic test_fills;
    lst[0] = {2'd0, 9'h111, 9'd4};
    lst[1] = {2'd1, 9'h1f8, 9'd0};
    lst[2] = {2'd1, 9'h007, 9'd0};
    lst[3] = {2'd0, 9'h0aa, 9'd15};  // ends on a line end
    lst[4] = {2'd1, 9'h140, 9'd0};
    lst[5] = {2'd2, 9'h1ff, 9'd0};
    lst_len = 6;
    run_list("fills", 2'd0, 1);
  endtask

  task automatic test_random;
    int i;
    lst_len = 10;
    for (i = 0; i < 9; i++)
      lst[i] = {2'($urandom % 2), 9'($urandom), 9'(12 + $urandom % 20)};
    lst[9] = {2'd2, 9'($urandom), 9'd0};
    run_list("random", 2'd1, 2);
  endtask

  initial begin
    int lat;
    void'($urandom(42450));
    rst = 1'b1;
    spi_latency = 2'd0;
    passed = 0;
    failed = 0;
    test_reset_state;
    test_sync_shape;
    load_runs;
    run_list("runs", 2'd0, 1);
    test_fills;
    load_runs;
    for (lat = 0; lat < 4; lat++)
      run_list($sformatf("latency_%0d", lat), 2'(lat), 1);
    test_random;
    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== src.f ====
vga_stream_pkg.sv
word_stream_if.sv
qspi_reader.sv
prefetch_buffer.sv
instr_decoder.sv
vga_timing.sv
vga_stream_top.sv
flash_model.sv
tb_vga_stream.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_vga_stream -o sim_vga
./obj_dir/sim_vga > sim.log
cat sim.log
grep -q "STATUS: PASS" sim.log
